// ==== lru_line_cache.f ====
common/cache_geom_pkg.sv
common/cache_line_pkg.sv
cache/line_ram.sv
cache/valid_table.sv
cache/way_match.sv
cache/line_update.sv
rtl/lru_line_cache.sv
test/clk_gen.sv
test/tb_lru_line_cache.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

top=tb_lru_line_cache

if ! verilator --binary --timing --timescale 1ns/1ps \
	--top-module "$top" -f lru_line_cache.f; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/V$top)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
	exit 0
fi

exit 1

// ==== test/tb_lru_line_cache.sv ====
module tb_lru_line_cache;

	timeunit 1ns;
	timeprecision 100ps;

	import cache_geom_pkg::*;
	import cache_line_pkg::*;

	// ============================================================
	// run length and limits
	// ============================================================

	localparam int unsigned rand_seed = 32'h1b1e_b07e;
	localparam int drive_delay = 2;
	localparam int ack_limit = 16;
	localparam int n_boot_reads = 16;
	localparam int n_wr_hits = 8;
	localparam int n_wr_miss = 4;
	localparam int n_mix = 400;
	// every read, write and fill counts as one operation
	localparam int total_ops = n_boot_reads + 2 + 10 + 3 * n_wr_hits + 2 * n_wr_miss + n_mix;
	// no operation takes more than a few cycles, ten each leaves plenty of room
	localparam int watchdog_cycles = total_ops * 10 + 200;

	logic wclk;
	logic rst;
	logic rd_stb;
	adr_t rd_adr;
	logic wr_stb;
	adr_t wr_adr;
	sel_t wr_sel;
	data_t wr_dat;
	logic ld_stb;
	adr_t ld_adr;
	data_t ld_dat;
	logic rd_done;
	logic rd_hit;
	data_t rd_dat;
	logic wr_ack;

	int checks = 0;
	int errors = 0;
	int test_errors_base = 0;

	// reference contents, one entry per set and way, way 0 is the newest fill
	way_vec_t mdl_vld [num_sets];
	tag_t mdl_tag [num_sets][num_ways];
	data_t mdl_dat [num_sets][num_ways];

	clk_gen u_clk_gen (
		.wclk(wclk),
		.rst(rst)
	);

	lru_line_cache uut (
		.wclk(wclk),
		.rst(rst),
		.rd_stb(rd_stb),
		.rd_adr(rd_adr),
		.wr_stb(wr_stb),
		.wr_adr(wr_adr),
		.wr_sel(wr_sel),
		.wr_dat(wr_dat),
		.ld_stb(ld_stb),
		.ld_adr(ld_adr),
		.ld_dat(ld_dat),
		.rd_done(rd_done),
		.rd_hit(rd_hit),
		.rd_dat(rd_dat),
		.wr_ack(wr_ack)
	);

	// ============================================================
	// reference model
	// ============================================================

	// the byte offset is the low two bits, the set index sits right above it
	function automatic idx_t line_index(adr_t adr);
		return adr[ofs_w +: idx_w];
	endfunction

	// and the tag takes whatever is left at the top
	function automatic tag_t line_tag(adr_t adr);
		return adr[adr_w-1 -: tag_w];
	endfunction

	// the offset within the line is irrelevant to the cache, so it is random
	function automatic adr_t make_adr(tag_t tag, idx_t idx);
		logic [ofs_w-1:0] ofs;
		ofs = ofs_w'($urandom);
		return {tag, idx, ofs};
	endfunction

	function automatic void clear_lines();
		for (int s = 0; s < num_sets; s++) begin
			mdl_vld[s] = '0;
			for (int w = 0; w < num_ways; w++) begin
				mdl_tag[s][w] = '0;
				mdl_dat[s][w] = '0;
			end
		end
	endfunction

	// first valid way holding the tag, or -1 when nothing matches
	function automatic int find_way(adr_t adr);
		idx_t s;
		tag_t t;
		int way;
		s = line_index(adr);
		t = line_tag(adr);
		way = -1;
		for (int w = 0; w < num_ways; w++) begin
			if (way < 0 && mdl_vld[s][w] && mdl_tag[s][w] == t) begin
				way = w;
			end
		end
		return way;
	endfunction

	function automatic void predict_read(adr_t adr, output logic hit, output data_t dat);
		int way;
		way = find_way(adr);
		hit = (way >= 0);
		dat = hit ? mdl_dat[line_index(adr)][way] : '0;
	endfunction

	// new line goes in at way 0, the rest move down one and way 3 falls out
	function automatic void apply_fill(adr_t adr, data_t dat);
		idx_t s;
		s = line_index(adr);
		for (int w = num_ways - 1; w > 0; w--) begin
			mdl_vld[s][w] = mdl_vld[s][w-1];
			mdl_tag[s][w] = mdl_tag[s][w-1];
			mdl_dat[s][w] = mdl_dat[s][w-1];
		end
		mdl_vld[s][0] = 1'b1;
		mdl_tag[s][0] = line_tag(adr);
		mdl_dat[s][0] = dat;
	endfunction

	// a miss leaves every line alone
	function automatic void apply_write(adr_t adr, sel_t sel, data_t dat);
		idx_t s;
		int way;
		s = line_index(adr);
		way = find_way(adr);
		if (way >= 0) begin
			for (int b = 0; b < line_bytes; b++) begin
				if (sel[b]) begin
					mdl_dat[s][way][8*b +: 8] = dat[8*b +: 8];
				end
			end
		end
	endfunction

	// ============================================================
	// compare tasks
	// ============================================================

	task automatic check_flag(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_data(string name, data_t got, data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_ack_delay(int got, int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("mismatch at %0t ns: wr_ack delay got %0d expected %0d cycles",
				$time, got, exp);
		end
	endtask

	// ============================================================
	// bus operations
	// ============================================================

	// inputs always change a little after the rising edge
	task automatic step_cycle();
		@(posedge wclk);
		#drive_delay;
	endtask

	// one request, answered exactly one cycle later
	// calling it again straight away gives back to back reads
	task automatic read_line(adr_t adr, logic exp_hit, data_t exp_dat);
		rd_stb = 1'b1;
		rd_adr = adr;
		step_cycle();
		rd_stb = 1'b0;
		check_flag("rd_done", rd_done, 1'b1);
		check_flag("rd_hit", rd_hit, exp_hit);
		check_data("rd_dat", rd_dat, exp_dat);
	endtask

	task automatic read_checked(adr_t adr);
		logic hit;
		data_t dat;
		predict_read(adr, hit, dat);
		read_line(adr, hit, dat);
	endtask

	// the strobe is held until the acknowledge, then low for one edge
	// so that the sequencer returns to idle before the next write
	task automatic write_line(adr_t adr, sel_t sel, data_t dat);
		int waited;
		wr_stb = 1'b1;
		wr_adr = adr;
		wr_sel = sel;
		wr_dat = dat;
		step_cycle();
		waited = 1;
		while (!wr_ack && waited < ack_limit) begin
			step_cycle();
			waited++;
		end
		if (wr_ack) begin
			check_ack_delay(waited, 2);
		end else begin
			errors++;
			$display("no wr_ack for the write to %h within %0d cycles", adr, ack_limit);
		end
		wr_stb = 1'b0;
		apply_write(adr, sel, dat);
		step_cycle();
	endtask

	// the set is read one edge after the strobe and written on the next,
	// so a read issued on return already sees the new line
	task automatic fill_line(adr_t adr, data_t dat);
		ld_stb = 1'b1;
		ld_adr = adr;
		ld_dat = dat;
		step_cycle();
		ld_stb = 1'b0;
		step_cycle();
		step_cycle();
		apply_fill(adr, dat);
	endtask

	// fills on consecutive cycles, each one reads the set while the one before writes it
	task automatic fill_burst(adr_t adrs [5], data_t dats [5]);
		ld_stb = 1'b1;
		for (int i = 0; i < 5; i++) begin
			ld_adr = adrs[i];
			ld_dat = dats[i];
			step_cycle();
		end
		ld_stb = 1'b0;
		step_cycle();
		step_cycle();
		for (int i = 0; i < 5; i++) begin
			apply_fill(adrs[i], dats[i]);
		end
	endtask

	task automatic report_test(int num, string name);
		$display("test %0d %s finished with %0d errors", num, name, errors - test_errors_base);
		test_errors_base = errors;
	endtask

	// ============================================================
	// watchdog
	// ============================================================

	initial begin
		repeat (watchdog_cycles) @(posedge wclk);
		$display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
		$display("RESULT: FAIL");
		$finish;
	end

	// ============================================================
	// test sequence
	// ============================================================

	initial begin
		adr_t adr;
		data_t dat;
		logic hit;
		tag_t base_tag;
		idx_t set_idx;
		adr_t fill_adr [5];
		data_t fill_dat [5];
		int unsigned pick;

		rd_stb = 1'b0;
		rd_adr = '0;
		wr_stb = 1'b0;
		wr_adr = '0;
		wr_sel = '0;
		wr_dat = '0;
		ld_stb = 1'b0;
		ld_adr = '0;
		ld_dat = '0;
		void'($urandom(rand_seed));
		clear_lines();
		@(negedge rst);

		// nothing is valid yet, every read misses and returns zero
		for (int i = 0; i < n_boot_reads; i++) begin
			read_line(adr_t'($urandom), 1'b0, '0);
		end
		step_cycle();
		check_flag("rd_done", rd_done, 1'b0);
		report_test(1, "reads after reset");

		adr = adr_t'($urandom);
		dat = data_t'($urandom);
		fill_line(adr, dat);
		read_line(adr, 1'b1, dat);
		report_test(2, "fill then read");

		// five distinct tags into one set push out the oldest one
		// whatever the set held before is gone after four of them
		// they go in back to back so every fill depends on the previous one's write
		set_idx = idx_t'($urandom);
		base_tag = tag_t'($urandom);
		for (int i = 0; i < 5; i++) begin
			fill_adr[i] = make_adr(tag_t'(base_tag + tag_t'(i)), set_idx);
			fill_dat[i] = data_t'($urandom);
		end
		fill_burst(fill_adr, fill_dat);
		read_line(fill_adr[0], 1'b0, '0);
		for (int i = 1; i < 5; i++) begin
			read_line(fill_adr[i], 1'b1, fill_dat[i]);
		end
		report_test(3, "eviction of the oldest way");

		for (int i = 0; i < n_wr_hits; i++) begin
			adr = adr_t'($urandom);
			fill_line(adr, data_t'($urandom));
			write_line(adr, sel_t'($urandom), data_t'($urandom));
			read_checked(adr);
		end
		report_test(4, "write hit byte merge");

		// look for an address that the model says is not cached
		for (int i = 0; i < n_wr_miss; i++) begin
			do begin
				adr = adr_t'($urandom);
				predict_read(adr, hit, dat);
			end while (hit);
			write_line(adr, sel_t'($urandom), data_t'($urandom));
			read_line(adr, 1'b0, '0);
		end
		report_test(5, "write miss");

		// few sets and few tags keep the hit rate and the evictions up
		for (int i = 0; i < n_mix; i++) begin
			adr = make_adr(tag_t'($urandom % 6), idx_t'($urandom % 3));
			pick = $urandom % 10;
			if (pick < 4) begin
				read_checked(adr);
			end else if (pick < 7) begin
				write_line(adr, sel_t'($urandom), data_t'($urandom));
			end else begin
				fill_line(adr, data_t'($urandom));
			end
		end
		report_test(6, "random mix");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== test/clk_gen.sv ====
module clk_gen (
	output logic wclk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	// 40 ns period, so each phase lasts 20 ns
	localparam int half_period = 20;
	localparam int rst_cycles = 8;
	// reset drops just after an edge, like every other driven input
	localparam int release_delay = 2;

	initial begin
		wclk = 1'b0;
		forever #half_period wclk = ~wclk;
	end

	initial begin
		rst = 1'b1;
		repeat (rst_cycles) @(posedge wclk);
		#release_delay rst = 1'b0;
	end

endmodule

// ==== rtl/lru_line_cache.sv ====
module lru_line_cache (
	input logic wclk,
	input logic rst,
	input logic rd_stb,
	input cache_geom_pkg::adr_t rd_adr,
	input logic wr_stb,
	input cache_geom_pkg::adr_t wr_adr,
	input cache_geom_pkg::sel_t wr_sel,
	input cache_geom_pkg::data_t wr_dat,
	input logic ld_stb,
	input cache_geom_pkg::adr_t ld_adr,
	input cache_geom_pkg::data_t ld_dat,
	output logic rd_done,
	output logic rd_hit,
	output cache_geom_pkg::data_t rd_dat,
	output logic wr_ack
);

	import cache_geom_pkg::*;
	import cache_line_pkg::*;

	tag_t rd_tag_r;
	set_t rd_set;
	set_t up_set;
	way_vec_t rd_valid;
	way_vec_t up_valid;
	logic rd_match;
	data_t rd_match_dat;
	idx_t up_idx;
	tag_t up_tag;
	logic up_hit;
	way_t up_way;
	logic ram_wr_en;
	idx_t ram_wr_idx;
	set_t ram_wr_set;
	logic fill_en;
	logic mark_en;
	way_t mark_way;

	// ============================================================
	// read lookup pipeline
	// ============================================================

	// strobe and tag are delayed one cycle to meet the memory output
	always_ff @(posedge wclk) begin
		if (rst) begin
			rd_done <= 1'b0;
		end else begin
			rd_done <= rd_stb;
		end
	end

	always_ff @(posedge wclk) begin
		rd_tag_r <= adr_tag(rd_adr);
	end

	// hit and data only mean something in the rd_done cycle
	assign rd_hit = rd_done & rd_match;
	assign rd_dat = rd_done ? rd_match_dat : '0;

	line_ram u_line_ram (
		.wclk(wclk),
		.rd_idx(adr_idx(rd_adr)),
		.up_idx(up_idx),
		.wr_en(ram_wr_en),
		.wr_idx(ram_wr_idx),
		.wr_set(ram_wr_set),
		.rd_set(rd_set),
		.up_set(up_set)
	);

	// fill and mark both act on the set that the updater is writing
	valid_table u_valid_table (
		.wclk(wclk),
		.rst(rst),
		.rd_idx(adr_idx(rd_adr)),
		.up_idx(up_idx),
		.fill_en(fill_en),
		.fill_idx(ram_wr_idx),
		.mark_en(mark_en),
		.mark_idx(ram_wr_idx),
		.mark_way(mark_way),
		.rd_valid(rd_valid),
		.up_valid(up_valid)
	);

	way_match way_match_rd (
		.set_in(rd_set),
		.valid(rd_valid),
		.tag(rd_tag_r),
		.hit_vec(),
		.hit(rd_match),
		.hit_way(),
		.hit_dat(rd_match_dat)
	);

	// the update side needs only the hit and the way number
	way_match way_match_up (
		.set_in(up_set),
		.valid(up_valid),
		.tag(up_tag),
		.hit_vec(),
		.hit(up_hit),
		.hit_way(up_way),
		.hit_dat()
	);

	line_update u_line_update (
		.wclk(wclk),
		.rst(rst),
		.wr_stb(wr_stb),
		.wr_adr(wr_adr),
		.wr_sel(wr_sel),
		.wr_dat(wr_dat),
		.ld_stb(ld_stb),
		.ld_adr(ld_adr),
		.ld_dat(ld_dat),
		.up_set(up_set),
		.up_hit(up_hit),
		.up_way(up_way),
		.up_idx(up_idx),
		.up_tag(up_tag),
		.ram_wr_en(ram_wr_en),
		.ram_wr_idx(ram_wr_idx),
		.ram_wr_set(ram_wr_set),
		.fill_en(fill_en),
		.mark_en(mark_en),
		.mark_way(mark_way),
		.wr_ack(wr_ack)
	);

endmodule

// ==== cache/line_update.sv ====
module line_update (
	input logic wclk,
	input logic rst,
	input logic wr_stb,
	input cache_geom_pkg::adr_t wr_adr,
	input cache_geom_pkg::sel_t wr_sel,
	input cache_geom_pkg::data_t wr_dat,
	input logic ld_stb,
	input cache_geom_pkg::adr_t ld_adr,
	input cache_geom_pkg::data_t ld_dat,
	input cache_line_pkg::set_t up_set,
	input logic up_hit,
	input cache_geom_pkg::way_t up_way,
	output cache_geom_pkg::idx_t up_idx,
	output cache_geom_pkg::tag_t up_tag,
	output logic ram_wr_en,
	output cache_geom_pkg::idx_t ram_wr_idx,
	output cache_line_pkg::set_t ram_wr_set,
	output logic fill_en,
	output logic mark_en,
	output cache_geom_pkg::way_t mark_way,
	output logic wr_ack
);

	import cache_geom_pkg::*;
	import cache_line_pkg::*;

	typedef enum logic [1:0] {
		w_idle,
		w_cmp,
		w_hold
	} wr_state_t;

	wr_state_t wr_state;
	logic ld_p1;
	logic ld_p2;
	adr_t p1_adr;
	data_t p1_dat;
	adr_t p2_adr;
	data_t p2_dat;
	logic fill_busy;
	logic fwd_en;
	idx_t fwd_idx;
	set_t fwd_set;
	set_t base_set;

	// ============================================================
	// fill pipeline
	// ============================================================

	// stage 1 reads the set through port b, stage 2 writes the shifted set
	// payload moves down with the strobe so back to back fills keep their data
	always_ff @(posedge wclk) begin
		if (rst) begin
			ld_p1 <= 1'b0;
			ld_p2 <= 1'b0;
		end else begin
			ld_p1 <= ld_stb;
			ld_p2 <= ld_p1;
		end
	end

	always_ff @(posedge wclk) begin
		p1_adr <= ld_adr;
		p1_dat <= ld_dat;
		p2_adr <= p1_adr;
		p2_dat <= p1_dat;
	end

	// a write must not read the set until the fill has landed in memory,
	// so the stage-2 cycle still counts as busy
	assign fill_busy = ld_stb | ld_p1 | ld_p2;

	// ============================================================
	// write sequencer
	// ============================================================

	// idle also acts as the lookup cycle, port b is addressed by wr_adr there
	// cmp sees the set and the hit result and writes the merge on its edge
	// hold waits for the host to drop wr_stb after the acknowledge
	always_ff @(posedge wclk) begin
		if (rst) begin
			wr_state <= w_idle;
			wr_ack <= 1'b0;
		end else begin
			wr_ack <= 1'b0;
			case (wr_state)
				w_idle: begin
					if (wr_stb && !fill_busy) begin
						wr_state <= w_cmp;
					end
				end
				w_cmp: begin
					// hit or miss, the write completes here
					wr_ack <= 1'b1;
					wr_state <= w_hold;
				end
				default: begin
					if (!wr_stb) begin
						wr_state <= w_idle;
					end
				end
			endcase
		end
	end

	// fill stage 1 owns port b, otherwise it follows the write address
	assign up_idx = ld_p1 ? adr_idx(p1_adr) : adr_idx(wr_adr);
	assign up_tag = adr_tag(wr_adr);

	// ============================================================
	// set builder
	// ============================================================

	// a port b read on the same edge as a memory write returns the old word
	// so the last written set is kept and used in its place when it matches
	always_ff @(posedge wclk) begin
		if (rst) begin
			fwd_en <= 1'b0;
		end else begin
			fwd_en <= ram_wr_en;
		end
	end

	always_ff @(posedge wclk) begin
		fwd_idx <= ram_wr_idx;
		fwd_set <= ram_wr_set;
	end

	always_comb begin
		if (fwd_en && (fwd_idx == ram_wr_idx)) begin
			base_set = fwd_set;
		end else begin
			base_set = up_set;
		end
	end

	always_comb begin
		ram_wr_en = 1'b0;
		fill_en = 1'b0;
		mark_en = 1'b0;
		mark_way = up_way;
		ram_wr_set = base_set;
		ram_wr_idx = ld_p2 ? adr_idx(p2_adr) : adr_idx(wr_adr);
		if (ld_p2) begin
			// ways shift down by one and way 3 is evicted
			for (int w = num_ways - 1; w > 0; w--) begin
				ram_wr_set[w] = base_set[w-1];
			end
			ram_wr_set[0].tag = adr_tag(p2_adr);
			ram_wr_set[0].data = p2_dat;
			ram_wr_en = 1'b1;
			fill_en = 1'b1;
		end else if ((wr_state == w_cmp) && up_hit) begin
			// only the enabled bytes of the hit way change, the tag stays
			for (int b = 0; b < line_bytes; b++) begin
				if (wr_sel[b]) begin
					ram_wr_set[up_way].data[8*b +: 8] = wr_dat[8*b +: 8];
				end
			end
			ram_wr_en = 1'b1;
			mark_en = 1'b1;
		end
	end

endmodule

// ==== cache/way_match.sv ====
module way_match (
	input cache_line_pkg::set_t set_in,
	input cache_line_pkg::way_vec_t valid,
	input cache_geom_pkg::tag_t tag,
	output cache_line_pkg::way_vec_t hit_vec,
	output logic hit,
	output cache_geom_pkg::way_t hit_way,
	output cache_geom_pkg::data_t hit_dat
);

	import cache_geom_pkg::*;
	import cache_line_pkg::*;

	// a way hits when its valid bit is set and its stored tag matches
	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			hit_vec[w] = valid[w] && (set_in[w].tag == tag);
		end
	end

	assign hit = |hit_vec;

	// lowest matching way wins
	// the fill path never stores two copies of one tag in a set,
	// but a host may fill the same line twice, so pick one deterministically
	always_comb begin
		hit_way = '0;
		for (int w = num_ways - 1; w >= 0; w--) begin
			if (hit_vec[w]) begin
				hit_way = way_t'(w);
			end
		end
	end

	// data of the hit way, zero on a miss so stale lines never leak out
	always_comb begin
		if (hit) begin
			hit_dat = set_in[hit_way].data;
		end else begin
			hit_dat = '0;
		end
	end

endmodule

// ==== cache/valid_table.sv ====
module valid_table (
	input logic wclk,
	input logic rst,
	input cache_geom_pkg::idx_t rd_idx,
	input cache_geom_pkg::idx_t up_idx,
	input logic fill_en,
	input cache_geom_pkg::idx_t fill_idx,
	input logic mark_en,
	input cache_geom_pkg::idx_t mark_idx,
	input cache_geom_pkg::way_t mark_way,
	output cache_line_pkg::way_vec_t rd_valid,
	output cache_line_pkg::way_vec_t up_valid
);

	import cache_geom_pkg::*;
	import cache_line_pkg::*;

	// ============================================================
	// valid vector storage
	// ============================================================

	// kept in flops rather than in the line memory
	// so that the whole table can be cleared in a single reset cycle
	way_vec_t vld [num_sets];

	always_ff @(posedge wclk) begin
		if (rst) begin
			for (int s = 0; s < num_sets; s++) begin
				vld[s] <= '0;
			end
		end else begin
			// a fill pushes every way down by one and the new line lands in way 0
			// whatever was valid in the last way simply drops off the end
			if (fill_en) begin
				vld[fill_idx] <= {vld[fill_idx][num_ways-2:0], 1'b1};
			end
			// a write hit sets the bit of the way it merged into
			// the way was already valid for the hit, so this only
			// keeps the table in step with the memory write
			if (mark_en) begin
				vld[mark_idx][mark_way] <= 1'b1;
			end
		end
	end

	// ============================================================
	// lookup outputs
	// ============================================================

	// both outputs are registered so they line up with the memory read ports
	// the vectors come from the table state before this edge's update
	always_ff @(posedge wclk) begin
		if (rst) begin
			rd_valid <= '0;
			up_valid <= '0;
		end else begin
			rd_valid <= vld[rd_idx];
			up_valid <= vld[up_idx];
		end
	end

endmodule

// ==== cache/line_ram.sv ====
module line_ram (
	input logic wclk,
	input cache_geom_pkg::idx_t rd_idx,
	input cache_geom_pkg::idx_t up_idx,
	input logic wr_en,
	input cache_geom_pkg::idx_t wr_idx,
	input cache_line_pkg::set_t wr_set,
	output cache_line_pkg::set_t rd_set,
	output cache_line_pkg::set_t up_set
);

	import cache_geom_pkg::*;
	import cache_line_pkg::*;

	// one word per set holding every way side by side
	// the contents start out unknown, the valid table hides them until a fill
	set_t mem [num_sets];

	// write port, driven only by the update sequencer
	always_ff @(posedge wclk) begin
		if (wr_en) begin
			mem[wr_idx] <= wr_set;
		end
	end

	// read port a serves the external read lookup
	// a read on the same edge as a write to that set returns the old word
	always_ff @(posedge wclk) begin
		rd_set <= mem[rd_idx];
	end

	// read port b serves the fill and write pipelines
	// the sequencer forwards its own last write to cover the same-edge case
	always_ff @(posedge wclk) begin
		up_set <= mem[up_idx];
	end

endmodule

// ==== common/cache_line_pkg.sv ====
package cache_line_pkg;

	// ============================================================
	// line and set layout
	// ============================================================

	// one cached line, tag in the upper bits and the data word below
	typedef struct packed {
		cache_geom_pkg::tag_t tag;
		cache_geom_pkg::data_t data;
	} line_t;

	// all ways of one set in a single memory word
	// index 0 is way 0, the most recently filled line
	typedef line_t [0:cache_geom_pkg::num_ways-1] set_t;

	// one bit per way, bit 0 belongs to way 0
	// used for the valid vectors and for the hit vectors
	typedef logic [cache_geom_pkg::num_ways-1:0] way_vec_t;

endpackage

// ==== common/cache_geom_pkg.sv ====
package cache_geom_pkg;

	// ============================================================
	// address geometry
	// ============================================================

	// a byte address splits into tag, set index and byte offset, from high to low
	localparam int adr_w = 16;
	localparam int ofs_w = 2;
	localparam int idx_w = 4;
	localparam int num_sets = 1 << idx_w;
	localparam int tag_w = adr_w - idx_w - ofs_w;
	localparam int num_ways = 4;
	localparam int line_bytes = 1 << ofs_w;

	typedef logic [adr_w-1:0] adr_t;
	typedef logic [idx_w-1:0] idx_t;
	typedef logic [tag_w-1:0] tag_t;
	typedef logic [$clog2(num_ways)-1:0] way_t;
	typedef logic [line_bytes-1:0] sel_t;
	typedef logic [8*line_bytes-1:0] data_t;

	// set index field of a byte address
	function automatic idx_t adr_idx(adr_t adr);
		return adr[ofs_w +: idx_w];
	endfunction

	// tag field, everything above the index
	function automatic tag_t adr_tag(adr_t adr);
		return adr[ofs_w+idx_w +: tag_w];
	endfunction

endpackage
